// ==== sources.f ====
xbar_cfg_pkg.sv
xbar_regs_pkg.sv
relay_if.sv
trig_matrix.sv
relay_driver.sv
xbar_regs.sv
trig_xbar_top.sv
trig_xbar_chk.sv
tb_trig_xbar.sv

// ==== run.sh ====
#!/bin/bash
# Build with Verilator, run, and pass only if the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_trig_xbar -o sim_trig_xbar &&
./obj_dir/sim_trig_xbar | tee /dev/stderr | grep -qx "Regression passed" &&
exit 0 || exit 1

// ==== tb_trig_xbar.sv ====
module tb_trig_xbar;

	////////////////////
	// Test constants

	localparam logic[11:0]	invert_mask = 12'h65;
	localparam logic[3:0]	sel_off = 4'd15;
	localparam int			led_hold = 16;
	localparam int			relay_pulse = 32;
	localparam logic[7:0]	addr_relay = 8'h40;
	localparam logic[7:0]	addr_status = 8'h44;
	localparam logic[7:0]	addr_activity = 8'h48;

	logic			clk_250mhz;
	logic			reset;
	logic			psel;
	logic			penable;
	logic			pwrite;
	logic[7:0]		paddr;
	logic[31:0]		pwdata;
	wire[31:0]		prdata;
	wire			pready;
	wire			pslverr;
	logic[11:0]		trig_in;
	wire[11:0]		trig_out;
	wire[11:0]		trig_in_led;
	wire[11:0]		trig_out_led;
	wire[3:0]		relay_a;
	wire[3:0]		relay_b;

	trig_xbar_top dut(.*);

	always #5 clk_250mhz = ~clk_250mhz;

	////////////////////
	// Reference model

	logic[3:0]		model_sel[12];
	logic[3:0]		model_state;
	// Cycles until the driver goes idle
	int				busy_cnt;
	logic[31:0]		lfsr_state = 32'h26fc_7548;
	int				errors;
	int				tests_run;
	int				tests_failed;

	always @(posedge clk_250mhz) begin
		if (busy_cnt > 0)
			busy_cnt = busy_cnt - 1;
	end

	// Galois LFSR, one step per bit
	function automatic logic[31:0] rand_bits(input int n);
		logic[31:0]	val;
		logic		lsb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb)
				lfsr_state = lfsr_state ^ 32'hD000_0001;
			val = {val[30:0], lsb};
		end
		return val;
	endfunction

	// Expected outputs for one input vector
	function automatic logic[11:0] route(input logic[11:0] tin);
		logic[11:0]	fixed;
		logic[11:0]	res;
		fixed = tin ^ invert_mask;
		res = '0;
		for (int i = 0; i < 12; i++) begin
			if (model_sel[i] < 4'd12)
				res[i] = fixed[model_sel[i]];
		end
		return res;
	endfunction

	task automatic check_val(input string name, input logic[31:0] got, input logic[31:0] exp);
		assert (got === exp) else begin
			$display("ERR %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	////////////////////
	// APB access

	// Entered and left on a falling edge with the bus idle
	task automatic apb_xfer(input logic wr, input logic[7:0] addr, input logic[31:0] wdata,
		output logic[31:0] rdata, output logic err);
		int	waited;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk_250mhz);
		penable = 1'b1;
		#1;
		waited = 0;
		while (!pready && waited < 16) begin
			@(negedge clk_250mhz);
			#1;
			waited++;
		end
		if (!pready) begin
			$display("APB transfer at address %h never completed", addr);
			errors++;
		end
		rdata = prdata;
		err = pslverr;
		@(negedge clk_250mhz);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic reg_write(input logic[7:0] addr, input logic[31:0] data, input logic exp_err);
		logic[31:0]	rd;
		logic		err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_val($sformatf("pslverr@%h", addr), {31'b0, err}, {31'b0, exp_err});
	endtask

	task automatic reg_read(input logic[7:0] addr, output logic[31:0] data);
		logic	err;
		apb_xfer(1'b0, addr, 32'h0, data, err);
		check_val($sformatf("pslverr@%h", addr), {31'b0, err}, 32'h0);
	endtask

	task automatic check_selects();
		logic[31:0]	rd;
		for (int i = 0; i < 12; i++) begin
			reg_read(8'(4 * i), rd);
			check_val($sformatf("muxsel[%0d]", i), rd, {28'b0, model_sel[i]});
		end
	endtask

	task automatic check_status();
		logic[31:0]	rd;
		reg_read(addr_status, rd);
		check_val("status", rd, {27'b0, busy_cnt != 0, model_state});
	endtask

	// Counts cycles with a leg high, bounded
	task automatic measure_pulse(input logic[3:0] exp_a, input logic[3:0] exp_b,
		output int width);
		width = 0;
		while ((relay_a | relay_b) != 4'b0 && width < 4 * relay_pulse) begin
			check_val("relay_a", {28'b0, relay_a}, {28'b0, exp_a});
			check_val("relay_b", {28'b0, relay_b}, {28'b0, exp_b});
			width++;
			@(negedge clk_250mhz);
		end
		if (width >= 4 * relay_pulse) begin
			$display("Relay pulse still running after %0d cycles", width);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before)
			$display("test %s: ok", name);
		else begin
			$display("test %s: %0d errors", name, errors - errs_before);
			tests_failed++;
		end
	endtask

	////////////////////
	// Tests

	task automatic test_routing();
		logic[11:0]	tin;
		logic[3:0]	sel;
		for (int r = 0; r < 4; r++) begin
			for (int i = 0; i < 12; i++) begin
				sel = 4'(rand_bits(4));
				// Make sure a parked output shows up every round
				if (i == 3 * r)
					sel = 4'(12 + r);
				reg_write(8'(4 * i), {28'b0, sel}, 1'b0);
				model_sel[i] = sel;
			end
			check_selects();
			for (int v = 0; v < 50; v++) begin
				tin = 12'(rand_bits(12));
				trig_in = tin;
				#1;
				check_val("trig_out", {20'b0, trig_out}, {20'b0, route(tin)});
				@(negedge clk_250mhz);
			end
		end
	endtask

	task automatic test_activity();
		int			k;
		int			m;
		logic[11:0]	in_hit;
		logic[11:0]	pulse_in;
		logic[11:0]	exp_out;
		logic[31:0]	rd;
		k = int'(rand_bits(4) % 12);
		m = int'(rand_bits(4) % 12);
		// Route the pulsed input to one output so an output stretcher sees it too
		reg_write(8'(4 * m), {28'b0, 4'(k)}, 1'b0);
		model_sel[m] = 4'(k);
		in_hit = 12'd1 << k;
		pulse_in = invert_mask ^ in_hit;
		exp_out = route(pulse_in);
		// All corrected inputs low, let the holds run out
		trig_in = invert_mask;
		repeat (led_hold + 2) @(negedge clk_250mhz);
		check_val("trig_in_led", {20'b0, trig_in_led}, 32'h0);
		check_val("trig_out_led", {20'b0, trig_out_led}, 32'h0);
		trig_in = pulse_in;
		@(negedge clk_250mhz);
		check_val("trig_in_led", {20'b0, trig_in_led}, {20'b0, in_hit});
		check_val("trig_out_led", {20'b0, trig_out_led}, {20'b0, exp_out});
		trig_in = invert_mask;
		repeat (led_hold) @(negedge clk_250mhz);
		check_val("trig_in_led", {20'b0, trig_in_led}, {20'b0, in_hit});
		check_val("trig_out_led", {20'b0, trig_out_led}, {20'b0, exp_out});
		@(negedge clk_250mhz);
		check_val("trig_in_led", {20'b0, trig_in_led}, 32'h0);
		check_val("trig_out_led", {20'b0, trig_out_led}, 32'h0);
		// Held level seen through the activity register
		trig_in = pulse_in;
		@(negedge clk_250mhz);
		reg_read(addr_activity, rd);
		check_val("activity", rd, {4'b0, exp_out, 4'b0, in_hit});
		trig_in = invert_mask;
	endtask

	task automatic test_relays();
		logic[1:0]	ch;
		logic		dir;
		logic[3:0]	leg;
		int			width;
		for (int c = 0; c < 6; c++) begin
			ch = 2'(rand_bits(2));
			dir = rand_bits(1) != 0;
			reg_write(addr_relay, {27'b0, dir, 2'b0, ch}, 1'b0);
			busy_cnt = relay_pulse;
			leg = 4'b1 << ch;
			measure_pulse(dir ? leg : 4'b0, dir ? 4'b0 : leg, width);
			check_val("pulse width", width, relay_pulse);
			model_state[ch] = dir;
			check_status();
		end
	endtask

	task automatic test_rejects();
		logic[1:0]	ch;
		logic		dir;
		logic[3:0]	leg;
		int			width;
		ch = 2'(rand_bits(2));
		dir = rand_bits(1) != 0;
		reg_write(addr_relay, {27'b0, dir, 2'b0, ch}, 1'b0);
		busy_cnt = relay_pulse;
		// Second command lands while the first still pulses
		reg_write(addr_relay, {27'b0, !dir, 2'b0, ch + 2'd1}, busy_cnt != 0);
		leg = 4'b1 << ch;
		measure_pulse(dir ? leg : 4'b0, dir ? 4'b0 : leg, width);
		model_state[ch] = dir;
		check_status();
		reg_write(8'h4C, rand_bits(32), 1'b1);
		reg_write(8'h32, rand_bits(32), 1'b1);
		check_selects();
	endtask

	initial begin
		int			mark;
		logic[31:0]	rd;
		clk_250mhz = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h0;
		pwdata = 32'h0;
		trig_in = 12'h0;
		busy_cnt = 0;
		model_state = 4'h0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < 12; i++)
			model_sel[i] = sel_off;
		repeat (3) @(posedge clk_250mhz);
		@(negedge clk_250mhz);
		reset = 1'b0;

		mark = errors;
		check_val("trig_out", {20'b0, trig_out}, 32'h0);
		check_val("relay_a", {28'b0, relay_a}, 32'h0);
		check_val("relay_b", {28'b0, relay_b}, 32'h0);
		check_selects();
		check_status();
		end_test("reset", mark);

		mark = errors;
		test_routing();
		end_test("routing", mark);

		mark = errors;
		test_activity();
		end_test("activity", mark);

		mark = errors;
		test_relays();
		end_test("relays", mark);

		mark = errors;
		test_rejects();
		end_test("rejects", mark);

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== trig_xbar_chk.sv ====
module trig_xbar_chk(
	input wire								clk_250mhz,
	input wire								reset,
	input wire								psel,
	input wire								penable,
	input wire								pslverr,
	input wire[xbar_cfg_pkg::num_relay-1:0]	relay_a,
	input wire[xbar_cfg_pkg::num_relay-1:0]	relay_b
);

	////////////////////
	// H-bridge safety

	// Set and reset sides together would fight over the coil
	a_b_apart: assert property (@(posedge clk_250mhz) disable iff (reset)
		!(|relay_a && |relay_b))
		else $error("relay_a and relay_b high in the same cycle");

	// One coil at a time on the shared supply
	one_leg: assert property (@(posedge clk_250mhz) disable iff (reset)
		$onehot0({relay_a, relay_b}))
		else $error("more than one relay leg high");

	////////////////////
	// APB

	// Error response only in the access phase
	err_in_access: assert property (@(posedge clk_250mhz) disable iff (reset)
		!(psel && penable) |-> !pslverr)
		else $error("pslverr high outside an access cycle");

endmodule

bind trig_xbar_top trig_xbar_chk chk(
	.clk_250mhz(clk_250mhz),
	.reset(reset),
	.psel(psel),
	.penable(penable),
	.pslverr(pslverr),
	.relay_a(relay_a),
	.relay_b(relay_b)
);

// ==== trig_xbar_top.sv ====
module trig_xbar_top(
	input wire										clk_250mhz,
	input wire										reset,

	// APB register port
	input wire										psel,
	input wire										penable,
	input wire										pwrite,
	input wire[xbar_regs_pkg::addr_w-1:0]			paddr,
	input wire[xbar_regs_pkg::data_w-1:0]			pwdata,
	output wire[xbar_regs_pkg::data_w-1:0]			prdata,
	output wire										pready,
	output wire										pslverr,

	// Trigger ports
	input wire[xbar_cfg_pkg::num_trig-1:0]			trig_in,
	output wire[xbar_cfg_pkg::num_trig-1:0]			trig_out,

	// Front panel activity
	output wire[xbar_cfg_pkg::num_trig-1:0]			trig_in_led,
	output wire[xbar_cfg_pkg::num_trig-1:0]			trig_out_led,

	// H-bridge control for relays
	output wire[xbar_cfg_pkg::num_relay-1:0]		relay_a,
	output wire[xbar_cfg_pkg::num_relay-1:0]		relay_b
);

	////////////////////
	// Relays

	relay_if	relay_bus();

	relay_driver relays(
		.clk_250mhz(clk_250mhz),
		.reset(reset),
		.relay(relay_bus.drv),
		.relay_a(relay_a),
		.relay_b(relay_b)
	);

	////////////////////
	// The crossbar itself

	xbar_cfg_pkg::muxsel_t[xbar_cfg_pkg::num_trig-1:0]	muxsel;

	trig_matrix matrix(
		.clk_250mhz(clk_250mhz),
		.reset(reset),
		.trig_in(trig_in),
		.muxsel(muxsel),
		.trig_out(trig_out),
		.trig_in_led(trig_in_led),
		.trig_out_led(trig_out_led)
	);

	////////////////////
	// Register block

	// Selects out, relay commands out, status and activity back in
	xbar_regs regs(
		.clk_250mhz(clk_250mhz),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.muxsel(muxsel),
		.trig_in_led(trig_in_led),
		.trig_out_led(trig_out_led),
		.relay(relay_bus.regs)
	);

endmodule

// ==== xbar_regs.sv ====
module xbar_regs(
	input wire										clk_250mhz,
	input wire										reset,

	// APB slave
	input wire										psel,
	input wire										penable,
	input wire										pwrite,
	input wire[xbar_regs_pkg::addr_w-1:0]			paddr,
	input wire[xbar_regs_pkg::data_w-1:0]			pwdata,
	output logic[xbar_regs_pkg::data_w-1:0]			prdata,
	output wire										pready,
	output wire										pslverr,

	// Crossbar routing
	output xbar_cfg_pkg::muxsel_t[xbar_cfg_pkg::num_trig-1:0]	muxsel,

	// Activity readback
	input wire[xbar_cfg_pkg::num_trig-1:0]			trig_in_led,
	input wire[xbar_cfg_pkg::num_trig-1:0]			trig_out_led,

	// Relay commands and status
	relay_if.regs									relay
);

	////////////////////
	// Address decode

	// No wait states
	assign pready = 1'b1;

	wire	access;
	wire	wr;
	assign access	= psel && penable;
	assign wr		= access && pwrite;

	// Offset into the select block
	// Addresses below the base wrap high and miss
	wire[xbar_regs_pkg::addr_w-1:0]	mux_off;
	assign mux_off = paddr - xbar_regs_pkg::addr_mux_base;

	wire	mux_hit;
	assign mux_hit = (mux_off < xbar_regs_pkg::mux_span) && (mux_off[1:0] == 2'b00);

	// Which output the select belongs to
	wire[3:0]	mux_idx;
	assign mux_idx = mux_off[5:2];

	wire	relay_hit;
	wire	status_hit;
	wire	act_hit;
	assign relay_hit	= (paddr == xbar_regs_pkg::addr_relay);
	assign status_hit	= (paddr == xbar_regs_pkg::addr_status);
	assign act_hit		= (paddr == xbar_regs_pkg::addr_activity);

	wire	unmapped;
	assign unmapped = !(mux_hit || relay_hit || status_hit || act_hit);

	// Bad address, or relay still pulsing
	assign pslverr = access && (unmapped || (pwrite && relay_hit && relay.busy));

	////////////////////
	// Write path

	// Reinterpret the bus word according to the target register
	xbar_regs_pkg::wdata_u	wword;
	assign wword = pwdata;

	always_ff @(posedge clk_250mhz) begin
		if (reset) begin
			for (int i = 0; i < xbar_cfg_pkg::num_trig; i++)
				muxsel[i]	<= xbar_cfg_pkg::muxsel_off;
		end
		else if (wr && mux_hit)
			muxsel[mux_idx]	<= wword.mux.sel;
	end

	// Relay toggle fires in the access cycle so the driver latches it at the write edge
	assign relay.start		= wr && relay_hit && !relay.busy;
	assign relay.channel	= wword.relay.channel;
	assign relay.dir		= wword.relay.dir;

	////////////////////
	// Read path

	always_comb begin
		prdata = '0;

		if (mux_hit)
			prdata[$bits(xbar_cfg_pkg::muxsel_t)-1:0] = muxsel[mux_idx];

		// Busy above the four position bits
		else if (status_hit) begin
			prdata[xbar_cfg_pkg::num_relay-1:0]			= relay.state;
			prdata[xbar_regs_pkg::status_busy_bit]		= relay.busy;
		end

		else if (act_hit) begin
			prdata[xbar_cfg_pkg::num_trig-1:0]					= trig_in_led;
			prdata[xbar_regs_pkg::act_out_lsb +: xbar_cfg_pkg::num_trig]	= trig_out_led;
		end
	end

endmodule

// ==== relay_driver.sv ====
module relay_driver(
	input wire										clk_250mhz,
	input wire										reset,

	// Commands in, status out
	relay_if.drv									relay,

	// H-bridge legs, one pair per relay
	output logic[xbar_cfg_pkg::num_relay-1:0]		relay_a,
	output logic[xbar_cfg_pkg::num_relay-1:0]		relay_b
);

	////////////////////
	// Command capture

	// Channel and direction of the toggle in flight
	logic[xbar_cfg_pkg::relay_ch_w-1:0]	cur_channel;
	logic								cur_dir;

	// Remaining pulse cycles
	logic[xbar_cfg_pkg::relay_cnt_w-1:0]	pulse_cnt;

	// One-hot leg for the requested channel
	wire[xbar_cfg_pkg::num_relay-1:0]	leg_sel;
	assign leg_sel = {{(xbar_cfg_pkg::num_relay-1){1'b0}}, 1'b1} << relay.channel;

	// Accept only when idle
	wire	accept;
	assign accept = relay.start && !relay.busy;

	always_ff @(posedge clk_250mhz) begin
		if (accept) begin
			cur_channel	<= relay.channel;
			cur_dir		<= relay.dir;
		end
	end

	////////////////////
	// Pulse sequencing

	always_ff @(posedge clk_250mhz) begin
		if (reset) begin
			relay.busy	<= 1'b0;
			relay.state	<= '0;
			pulse_cnt	<= '0;
			relay_a		<= '0;
			relay_b		<= '0;
		end

		// Idle, wait for a command
		else if (!relay.busy) begin
			if (relay.start) begin
				relay.busy	<= 1'b1;
				pulse_cnt	<= xbar_cfg_pkg::relay_last[xbar_cfg_pkg::relay_cnt_w-1:0];

				// A leg sets, B leg resets
				relay_a		<= relay.dir ? leg_sel : '0;
				relay_b		<= relay.dir ? '0 : leg_sel;
			end
		end

		// Last pulse cycle, release the bridge and latch the new position
		else if (pulse_cnt == 0) begin
			relay.busy					<= 1'b0;
			relay_a						<= '0;
			relay_b						<= '0;
			relay.state[cur_channel]	<= cur_dir;
		end

		else
			pulse_cnt	<= pulse_cnt - 1'b1;
	end

endmodule

// ==== trig_matrix.sv ====
module trig_matrix(
	input wire										clk_250mhz,
	input wire										reset,

	// Trigger inputs as they arrive from the pads
	input wire[xbar_cfg_pkg::num_trig-1:0]			trig_in,

	// Routing for each output
	input xbar_cfg_pkg::muxsel_t[xbar_cfg_pkg::num_trig-1:0]	muxsel,

	output logic[xbar_cfg_pkg::num_trig-1:0]		trig_out,

	// Stretched levels for the front panel
	output wire[xbar_cfg_pkg::num_trig-1:0]			trig_in_led,
	output wire[xbar_cfg_pkg::num_trig-1:0]			trig_out_led
);

	////////////////////
	// Polarity fix

	// Undo the board swaps before anything looks at the inputs
	wire[xbar_cfg_pkg::num_trig-1:0]	trig_fix;
	assign trig_fix = trig_in ^ xbar_cfg_pkg::trig_invert_mask;

	////////////////////
	// Routing

	// Purely combinational path from pad to output
	always_comb begin
		for (int i = 0; i < xbar_cfg_pkg::num_trig; i++) begin
			// Selects past the last input park the output low
			if (muxsel[i] < xbar_cfg_pkg::num_trig)
				trig_out[i] = trig_fix[muxsel[i]];
			else
				trig_out[i] = 1'b0;
		end
	end

	////////////////////
	// Activity stretch

	// Inputs in the low half, outputs in the high half
	wire[2*xbar_cfg_pkg::num_trig-1:0]	act_level;
	logic[2*xbar_cfg_pkg::num_trig-1:0]	act_led;
	logic[xbar_cfg_pkg::led_hold_w-1:0]	hold_cnt[2*xbar_cfg_pkg::num_trig];

	assign act_level = {trig_out, trig_fix};

	always_ff @(posedge clk_250mhz) begin
		for (int i = 0; i < 2*xbar_cfg_pkg::num_trig; i++) begin
			if (reset) begin
				hold_cnt[i]	<= '0;
				act_led[i]	<= 1'b0;
			end

			// Level high, rearm the hold
			else if (act_level[i]) begin
				hold_cnt[i]	<= xbar_cfg_pkg::led_hold[xbar_cfg_pkg::led_hold_w-1:0];
				act_led[i]	<= 1'b1;
			end

			// Level low, ride out the remaining hold
			else begin
				act_led[i]	<= (hold_cnt[i] != 0);
				if (hold_cnt[i] != 0)
					hold_cnt[i]	<= hold_cnt[i] - 1'b1;
			end
		end
	end

	assign trig_in_led	= act_led[xbar_cfg_pkg::num_trig-1:0];
	assign trig_out_led	= act_led[2*xbar_cfg_pkg::num_trig-1:xbar_cfg_pkg::num_trig];

endmodule

// ==== relay_if.sv ====
interface relay_if;

	// Toggle request, one cycle wide
	logic	start;

	// Which relay and which leg
	logic[xbar_cfg_pkg::relay_ch_w-1:0]	channel;
	logic								dir;

	// Driver still pulsing a coil
	logic	busy;

	// Last commanded position of each relay
	logic[xbar_cfg_pkg::num_relay-1:0]	state;

	// Register block issues commands, reads status back
	modport regs(
		output start, channel, dir,
		input busy, state
	);

	// Driver consumes commands
	modport drv(
		input start, channel, dir,
		output busy, state
	);

endinterface

// ==== xbar_regs_pkg.sv ====
package xbar_regs_pkg;

	////////////////////
	// APB side

	localparam int addr_w = 8;
	localparam int data_w = 32;

	////////////////////
	// Register map

	// One select word per output, 4 byte stride
	localparam logic[addr_w-1:0] addr_mux_base = 8'h00;
	localparam int mux_span = 4 * xbar_cfg_pkg::num_trig;

	// Relay toggle command, write only
	localparam logic[addr_w-1:0] addr_relay = 8'h40;

	// Relay busy and latched positions
	localparam logic[addr_w-1:0] addr_status = 8'h44;
	localparam int status_busy_bit = 4;

	// Stretched activity bits
	// Inputs at the bottom, outputs from bit 16
	localparam logic[addr_w-1:0] addr_activity = 8'h48;
	localparam int act_out_lsb = 16;

	////////////////////
	// Write word views

	// Select register layout
	typedef struct packed {
		logic[27:0]				rsvd;
		xbar_cfg_pkg::muxsel_t	sel;
	} mux_word_t;

	// Relay command layout
	typedef struct packed {
		logic[26:0]	rsvd_hi;
		logic		dir;
		logic[1:0]	rsvd_lo;
		logic[1:0]	channel;
	} relay_word_t;

	// Same bus word, picked apart by address
	typedef union packed {
		mux_word_t		mux;
		relay_word_t	relay;
	} wdata_u;

endpackage

// ==== xbar_cfg_pkg.sv ====
package xbar_cfg_pkg;

	////////////////////
	// Crossbar sizing

	// Trigger ports on each side of the matrix
	localparam int num_trig = 12;

	// Latching relays on the front panel
	localparam int num_relay = 4;
	localparam int relay_ch_w = $clog2(num_relay);

	// Per-output select
	// 0 to 11 routes that input, 12 and up parks the output low
	typedef logic[3:0] muxsel_t;
	localparam muxsel_t muxsel_off = 4'd15;

	// Inputs routed with P and N swapped on the board
	localparam logic[num_trig-1:0] trig_invert_mask = 12'h65;

	////////////////////
	// Timing

	// Activity LED hold after a level falls
	localparam int led_hold = 16;
	localparam int led_hold_w = $clog2(led_hold + 1);

	// H-bridge drive time for one relay toggle
	localparam int relay_pulse = 32;
	localparam int relay_last = relay_pulse - 1;
	localparam int relay_cnt_w = $clog2(relay_pulse);

endpackage
